// File: tb.f
source/usb_ctl_pkg.sv
source/setup_packet_parser.sv
source/std_request_decoder.sv
source/descriptor_rom.sv
source/ctl_pipe0.sv
source/usb_ctl_top.sv
tests/usb_ctl_chk.sv
tests/usb_ctl_tb.sv

// File: tests/usb_ctl_tb.sv
module usb_ctl_tb
  import usb_ctl_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_TRANSFERS   = 40;
  // Setup bytes with gaps, pipeline latency, longest stream with every stall, status stage
  localparam int TRANSFER_CYCLES = 16 + 10 + DEVICE_DESC_LEN * 4 + 10;
  localparam int WATCHDOG_NS     = MAX_TRANSFERS * TRANSFER_CYCLES * 4;

  logic       clock;
  logic       reset;
  logic       setup_valid_i;
  logic [7:0] setup_data_i;
  logic       status_i;
  logic       m_tready_i;
  logic       accept_o;
  logic       error_o;
  logic [6:0] usb_addr_o;
  logic [7:0] usb_conf_o;
  logic       configured_o;
  logic       m_tvalid_o;
  logic [7:0] m_tdata_o;
  logic       m_tlast_o;

  int         errors;
  int         test_errors;
  int         tests_run;
  logic [6:0] model_addr;
  logic [7:0] model_conf;
  logic       model_configured;

  usb_ctl_top uut (.*);

  initial begin
    clock = 1'b0;
    forever #2 clock = ~clock;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Watchdog expired after %0d ns, a transfer never completed", WATCHDOG_NS);
    $display("** FAIL **");
    $finish;
  end

  task automatic compare_value(string name, logic [15:0] got, logic [15:0] exp);
    assert (got === exp) else begin
      $display("FAILED %s: got %h, expected %h", name, got, exp);
      test_errors++;
    end
  endtask

  task automatic require(bit cond, string what);
    assert (cond) else begin
      $display("%s", what);
      test_errors++;
    end
  endtask

  task automatic check_registers();
    compare_value("usb_addr_o", usb_addr_o, model_addr);
    compare_value("usb_conf_o", usb_conf_o, model_conf);
    compare_value("configured_o", configured_o, model_configured);
  endtask

  // Standard device request rules with recipient and type both zero
  function automatic std_request_e expected_kind(setup_packet_t p);
    logic         dir_in;
    std_request_e kind;
    dir_in = p.bm_request_type[7];
    kind   = REQ_NONE;
    if (p.bm_request_type[6:5] != 2'd0 || p.bm_request_type[4:0] != 5'd0)
      kind = REQ_NONE;
    else if (dir_in && p.b_request == 8'd6 && p.w_value[15:8] == 8'd1)
      kind = REQ_GET_DEVICE_DESC;
    else if (dir_in && p.b_request == 8'd6 && p.w_value[15:8] == 8'd2)
      kind = REQ_GET_CONFIG_DESC;
    else if (dir_in && p.b_request == 8'd6 && p.w_value[15:8] == 8'd3)
      kind = REQ_GET_STRING_DESC;
    else if (!dir_in && p.b_request == 8'd5)
      kind = REQ_SET_ADDRESS;
    else if (!dir_in && p.b_request == 8'd9)
      kind = REQ_SET_CONFIG;
    return kind;
  endfunction

  // Zero length means no descriptor for this kind and index
  function automatic void desc_span(input std_request_e kind, input logic [7:0] index,
                                    output int start, output int len);
    start = 0;
    len   = 0;
    if (kind == REQ_GET_DEVICE_DESC) begin
      len = DEVICE_DESC_LEN;
    end else if (kind == REQ_GET_CONFIG_DESC) begin
      start = CONFIG_START;
      len   = CONFIG_DESC_LEN;
    end else if (kind == REQ_GET_STRING_DESC && index == 8'd0) begin
      start = LANG_START;
      len   = LANG_DESC_LEN;
    end else if (kind == REQ_GET_STRING_DESC && index == 8'd1) begin
      start = PRODUCT_START;
      len   = PRODUCT_STR_LEN;
    end
  endfunction

  function automatic setup_packet_t make_packet(logic [7:0] bm, logic [7:0] req,
                                                logic [15:0] value, logic [15:0] length);
    return '{bm, req, value, 16'($urandom), length};
  endfunction

  task automatic run_request(input setup_packet_t p, input bit stalls, input int cut_at);
    std_request_e kind;
    logic [7:0]   wire_bytes [8];
    int           start;
    int           len;
    int           n;
    int           idx;
    int           wait_cycles;
    int           stall_run;
    bit           is_get;
    bit           ok;
    kind = expected_kind(p);
    desc_span(kind, p.w_value[7:0], start, len);
    is_get = kind inside {REQ_GET_DEVICE_DESC, REQ_GET_CONFIG_DESC, REQ_GET_STRING_DESC};
    ok     = (kind != REQ_NONE) && !(is_get && len == 0);
    n      = (int'(p.w_length) < len) ? int'(p.w_length) : len;
    wire_bytes = '{p.bm_request_type, p.b_request, p.w_value[7:0], p.w_value[15:8],
                   p.w_index[7:0], p.w_index[15:8], p.w_length[7:0], p.w_length[15:8]};
    for (int b = 0; b < 8; b++) begin
      if (b > 0)
        repeat ($urandom_range(0, 1)) @(negedge clock);
      setup_valid_i = 1'b1;
      setup_data_i  = wire_bytes[b];
      @(negedge clock);
      setup_valid_i = 1'b0;
    end
    wait_cycles = 1;
    while (!(accept_o || error_o) && wait_cycles < 10) begin
      @(negedge clock);
      wait_cycles++;
    end
    if (!(accept_o || error_o)) begin
      require(1'b0, "No accept or error pulse after the setup packet");
      return;
    end
    require(wait_cycles == 3, "Response did not come 3 cycles after the last setup byte");
    compare_value("accept_o", accept_o, ok);
    compare_value("error_o", error_o, !ok);
    compare_value("m_tvalid_o", m_tvalid_o, ok && n > 0);
    if (!ok) begin
      repeat (2) @(negedge clock);
      compare_value("m_tvalid_o", m_tvalid_o, 1'b0);
      check_registers();
      return;
    end
    idx         = 0;
    stall_run   = 0;
    wait_cycles = 0;
    while (idx < n && wait_cycles < n * 4 + 8) begin
      if (idx == cut_at) begin
        // Host ends the data stage early
        m_tready_i = 1'b0;
        status_i   = 1'b1;
        @(negedge clock);
        status_i = 1'b0;
        compare_value("m_tvalid_o", m_tvalid_o, 1'b0);
        check_registers();
        return;
      end
      m_tready_i = !stalls || stall_run == 3 || $urandom_range(0, 2) != 0;
      stall_run  = m_tready_i ? 0 : stall_run + 1;
      require(m_tvalid_o, "Stream ended before all expected bytes were sent");
      if (!m_tvalid_o)
        break;
      if (m_tready_i) begin
        compare_value("m_tdata_o", m_tdata_o, DESC_ROM[start + idx]);
        compare_value("m_tlast_o", m_tlast_o, idx == n - 1);
        idx++;
      end
      @(negedge clock);
      wait_cycles++;
    end
    require(idx == n, "Stream did not deliver every expected byte in time");
    m_tready_i = 1'b0;
    compare_value("m_tvalid_o", m_tvalid_o, 1'b0);
    repeat ($urandom_range(0, 3)) @(negedge clock);
    check_registers();
    status_i = 1'b1;
    @(negedge clock);
    status_i = 1'b0;
    if (kind == REQ_SET_ADDRESS)
      model_addr = p.w_value[6:0];
    if (kind == REQ_SET_CONFIG) begin
      model_conf       = p.w_value[7:0];
      model_configured = p.w_value[7:0] != 8'd0;
    end
    check_registers();
  endtask

  task automatic finish_test(string name);
    tests_run++;
    errors += test_errors;
    $display("Test %0d %s: %s, %0d errors", tests_run, name,
             (test_errors == 0) ? "ok" : "failed", test_errors);
    test_errors = 0;
  endtask

  initial begin
    void'($urandom(32'ha5b9_bf6a));
    reset            = 1'b1;
    setup_valid_i    = 1'b0;
    setup_data_i     = 8'h00;
    status_i         = 1'b0;
    m_tready_i       = 1'b0;
    errors           = 0;
    test_errors      = 0;
    tests_run        = 0;
    model_addr       = 7'd0;
    model_conf       = 8'd0;
    model_configured = 1'b0;
    repeat (3) @(negedge clock);
    reset = 1'b0;

    compare_value("accept_o", accept_o, 1'b0);
    compare_value("error_o", error_o, 1'b0);
    compare_value("m_tvalid_o", m_tvalid_o, 1'b0);
    compare_value("m_tdata_o", m_tdata_o, 8'h00);
    compare_value("m_tlast_o", m_tlast_o, 1'b0);
    check_registers();
    run_request(make_packet(8'h80, 8'h06, 16'h0100, 16'($urandom_range(0, 40))), 1'b0, -1);
    finish_test("reset and device descriptor");

    for (int i = 0; i < 4; i++) begin
      run_request(make_packet(8'h80, 8'h06, 16'h0200, 16'($urandom_range(0, 40))), 1'b1, -1);
      run_request(make_packet(8'h80, 8'h06, 16'h0300, 16'($urandom_range(0, 8))), 1'b1, -1);
      run_request(make_packet(8'h80, 8'h06, 16'h0301, 16'($urandom_range(0, 20))), 1'b1, -1);
    end
    finish_test("configuration and string descriptors");

    repeat (3)
      run_request(make_packet(8'h00, 8'h05, 16'($urandom_range(1, 127)), 16'd0), 1'b1, -1);
    finish_test("set address");

    run_request(make_packet(8'h00, 8'h09, 16'($urandom_range(1, 255)), 16'd0), 1'b1, -1);
    run_request(make_packet(8'h00, 8'h09, 16'h0000, 16'd0), 1'b1, -1);
    run_request(make_packet(8'h00, 8'h09, 16'($urandom_range(1, 255)), 16'd0), 1'b1, -1);
    finish_test("set configuration");

    // Get status, wrong directions, other recipients and types, missing descriptors
    run_request(make_packet(8'h80, 8'h00, 16'h0000, 16'd2), 1'b1, -1);
    run_request(make_packet(8'h00, 8'h06, 16'h0100, 16'd18), 1'b1, -1);
    run_request(make_packet(8'h80, 8'h05, 16'h0011, 16'd0), 1'b1, -1);
    run_request(make_packet(8'h81, 8'h06, 16'h0100, 16'd18), 1'b1, -1);
    run_request(make_packet(8'hc0, 8'h06, 16'h0100, 16'd18), 1'b1, -1);
    run_request(make_packet(8'h80, 8'h06, 16'h0302, 16'd16), 1'b1, -1);
    run_request(make_packet(8'h80, 8'h06, 16'h03ff, 16'd16), 1'b1, -1);
    run_request(make_packet(8'h80, 8'h06, 16'h0600, 16'd10), 1'b1, -1);
    finish_test("unsupported requests");

    run_request(make_packet(8'h80, 8'h06, 16'h0100, 16'd64), 1'b1,
                $urandom_range(1, DEVICE_DESC_LEN - 1));
    run_request(make_packet(8'h80, 8'h06, 16'h0200, 16'd64), 1'b1, -1);
    finish_test("status during stream");

    errors += uut.u_pipe0.u_chk.fail_count;
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: tests/usb_ctl_chk.sv
module usb_ctl_chk (
  input logic       clock,
  input logic       reset,
  input logic       status_i,
  input logic       accept_o,
  input logic       error_o,
  input logic       m_tvalid_o,
  input logic       m_tready_i,
  input logic [7:0] m_tdata_o,
  input logic       m_tlast_o
);
  timeunit 1ns;
  timeprecision 1ps;

  // Read by the testbench at the end of the run
  int fail_count = 0;

  one_response: assert property (@(posedge clock) disable iff (reset)
    !(accept_o && error_o))
    else begin
      $error("accept_o and error_o are high in the same cycle");
      fail_count++;
    end

  // A stalled byte stays offered until taken or the host ends the transfer
  valid_held: assert property (@(posedge clock) disable iff (reset)
    m_tvalid_o && !m_tready_i && !status_i |=> m_tvalid_o)
    else begin
      $error("m_tvalid_o dropped without a transfer or a status strobe");
      fail_count++;
    end

  data_held: assert property (@(posedge clock) disable iff (reset)
    m_tvalid_o && !m_tready_i && !status_i |=> $stable(m_tdata_o) && $stable(m_tlast_o))
    else begin
      $error("m_tdata_o or m_tlast_o changed while stalled");
      fail_count++;
    end

  // Stream opens in the accept cycle
  stream_after_accept: assert property (@(posedge clock) disable iff (reset)
    $rose(m_tvalid_o) |-> accept_o)
    else begin
      $error("stream started without an accept");
      fail_count++;
    end

endmodule

bind ctl_pipe0 usb_ctl_chk u_chk (.*);

// File: source/usb_ctl_top.sv
module usb_ctl_top
  import usb_ctl_pkg::*;
(
  input  logic       clock,
  input  logic       reset,
  input  logic       setup_valid_i,
  input  logic [7:0] setup_data_i,
  input  logic       status_i,
  output logic       accept_o,
  output logic       error_o,
  output logic [6:0] usb_addr_o,
  output logic [7:0] usb_conf_o,
  output logic       configured_o,
  output logic       m_tvalid_o,
  input  logic       m_tready_i,
  output logic [7:0] m_tdata_o,
  output logic       m_tlast_o
);

  setup_packet_t setup;
  logic          setup_valid;
  ctl_request_t  request;
  logic          request_valid;

  setup_packet_parser u_parser (
    .clock         (clock),
    .reset         (reset),
    .setup_valid_i (setup_valid_i),
    .setup_data_i  (setup_data_i),
    .setup_o       (setup),
    .setup_valid_o (setup_valid)
  );

  std_request_decoder u_decoder (
    .clock           (clock),
    .reset           (reset),
    .setup_i         (setup),
    .setup_valid_i   (setup_valid),
    .request_o       (request),
    .request_valid_o (request_valid)
  );

  ctl_pipe0 u_pipe0 (
    .clock           (clock),
    .reset           (reset),
    .request_i       (request),
    .request_valid_i (request_valid),
    .status_i        (status_i),
    .accept_o        (accept_o),
    .error_o         (error_o),
    .usb_addr_o      (usb_addr_o),
    .usb_conf_o      (usb_conf_o),
    .configured_o    (configured_o),
    .m_tvalid_o      (m_tvalid_o),
    .m_tready_i      (m_tready_i),
    .m_tdata_o       (m_tdata_o),
    .m_tlast_o       (m_tlast_o)
  );

endmodule

// File: source/ctl_pipe0.sv
module ctl_pipe0
  import usb_ctl_pkg::*;
(
  input  logic         clock,
  input  logic         reset,
  input  ctl_request_t request_i,
  input  logic         request_valid_i,
  input  logic         status_i,
  output logic         accept_o,
  output logic         error_o,
  output logic [6:0]   usb_addr_o,
  output logic [7:0]   usb_conf_o,
  output logic         configured_o,
  output logic         m_tvalid_o,
  input  logic         m_tready_i,
  output logic [7:0]   m_tdata_o,
  output logic         m_tlast_o
);

  ctl_state_e             state_q;
  logic [DESC_ADDR_W-1:0] addr_q;
  logic [15:0]            count_q;
  logic [7:0]             pending_q;

  logic [DESC_ADDR_W-1:0] rom_start;
  logic [15:0]            rom_length;
  logic                   rom_found;
  logic [7:0]             rom_data;
  logic                   rom_last;

  logic                   is_get;
  logic                   is_bad;
  logic [15:0]            send_len;
  logic                   streaming;
  logic                   beat;

  descriptor_rom u_rom (
    .kind_i   (request_i.kind),
    .index_i  (request_i.desc_index),
    .addr_i   (addr_q),
    .start_o  (rom_start),
    .length_o (rom_length),
    .found_o  (rom_found),
    .data_o   (rom_data),
    .last_o   (rom_last)
  );

  assign is_get = request_i.kind inside {REQ_GET_DEVICE_DESC, REQ_GET_CONFIG_DESC,
                                         REQ_GET_STRING_DESC};
  assign is_bad = (request_i.kind == REQ_NONE) || (is_get && !rom_found);

  // Host may ask for less than the whole descriptor
  assign send_len = (request_i.length < rom_length) ? request_i.length : rom_length;

  assign streaming = state_q == CTL_STREAM;
  assign beat      = streaming && m_tready_i;

  assign m_tvalid_o = streaming;
  assign m_tdata_o  = streaming ? rom_data : 8'h00;
  assign m_tlast_o  = streaming && ((count_q == 16'd1) || rom_last);

  always_ff @(posedge clock) begin
    if (reset) begin
      state_q      <= CTL_IDLE;
      addr_q       <= '0;
      count_q      <= 16'd0;
      accept_o     <= 1'b0;
      error_o      <= 1'b0;
      usb_addr_o   <= 7'd0;
      usb_conf_o   <= 8'd0;
      configured_o <= 1'b0;
    end else begin
      accept_o <= 1'b0;
      error_o  <= 1'b0;
      case (state_q)
        CTL_IDLE: begin
          if (request_valid_i) begin
            if (is_bad) begin
              error_o <= 1'b1;
            end else begin
              accept_o <= 1'b1;
              if (is_get) begin
                addr_q  <= rom_start;
                count_q <= send_len;
                // Zero wLength goes straight to the status stage
                state_q <= (send_len == 16'd0) ? CTL_WAIT_STATUS : CTL_STREAM;
              end else if (request_i.kind == REQ_SET_ADDRESS) begin
                state_q <= CTL_WAIT_STATUS_ADDR;
              end else begin
                state_q <= CTL_WAIT_STATUS_CONF;
              end
            end
          end
        end
        CTL_STREAM: begin
          // Status from the host cuts the data stage short
          if (status_i) begin
            state_q <= CTL_IDLE;
          end else if (beat) begin
            addr_q  <= addr_q + DESC_ADDR_W'(1);
            count_q <= count_q - 16'd1;
            if (m_tlast_o) begin
              state_q <= CTL_WAIT_STATUS;
            end
          end
        end
        CTL_WAIT_STATUS_ADDR: begin
          if (status_i) begin
            usb_addr_o <= pending_q[6:0];
            state_q    <= CTL_IDLE;
          end
        end
        CTL_WAIT_STATUS_CONF: begin
          if (status_i) begin
            usb_conf_o   <= pending_q;
            configured_o <= pending_q != 8'd0;
            state_q      <= CTL_IDLE;
          end
        end
        default: begin
          if (status_i) begin
            state_q <= CTL_IDLE;
          end
        end
      endcase
      // Pipe is busy, refuse without touching the state
      if (request_valid_i && (state_q != CTL_IDLE)) begin
        error_o <= 1'b1;
      end
    end
  end

  // Value waits here until the status stage commits it
  always_ff @(posedge clock) begin
    if (request_valid_i && (state_q == CTL_IDLE)) begin
      pending_q <= request_i.value[7:0];
    end
  end

endmodule

// File: source/descriptor_rom.sv
module descriptor_rom
  import usb_ctl_pkg::*;
(
  input  std_request_e           kind_i,
  input  logic [7:0]             index_i,
  input  logic [DESC_ADDR_W-1:0] addr_i,
  output logic [DESC_ADDR_W-1:0] start_o,
  output logic [15:0]            length_o,
  output logic                   found_o,
  output logic [7:0]             data_o,
  output logic                   last_o
);

  // Addresses past the image read as zero
  assign data_o = (int'(addr_i) < DESC_SIZE) ? DESC_ROM[addr_i] : 8'h00;

  // Final byte of each descriptor
  assign last_o = (addr_i == DESC_ADDR_W'(CONFIG_START - 1))
               || (addr_i == DESC_ADDR_W'(LANG_START - 1))
               || (addr_i == DESC_ADDR_W'(PRODUCT_START - 1))
               || (addr_i == DESC_ADDR_W'(DESC_SIZE - 1));

  always_comb begin
    start_o  = '0;
    length_o = 16'd0;
    found_o  = 1'b0;
    case (kind_i)
      REQ_GET_DEVICE_DESC: begin
        length_o = 16'(DEVICE_DESC_LEN);
        found_o  = 1'b1;
      end
      REQ_GET_CONFIG_DESC: begin
        start_o  = DESC_ADDR_W'(CONFIG_START);
        length_o = 16'(CONFIG_DESC_LEN);
        found_o  = 1'b1;
      end
      REQ_GET_STRING_DESC: begin
        found_o = index_i < 8'(NUM_STRINGS);
        if (index_i == 8'd0) begin
          start_o  = DESC_ADDR_W'(LANG_START);
          length_o = 16'(LANG_DESC_LEN);
        end else begin
          start_o  = DESC_ADDR_W'(PRODUCT_START);
          length_o = 16'(PRODUCT_STR_LEN);
        end
      end
      default: begin
        found_o = 1'b0;
      end
    endcase
  end

endmodule

// File: source/std_request_decoder.sv
module std_request_decoder
  import usb_ctl_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  setup_packet_t setup_i,
  input  logic          setup_valid_i,
  output ctl_request_t  request_o,
  output logic          request_valid_o
);

  logic         is_std_dev;
  logic         dir_in;
  std_request_e kind;

  // Standard type, device recipient
  assign is_std_dev = setup_i.bm_request_type[6:0] == 7'd0;
  assign dir_in     = setup_i.bm_request_type[7];

  always_comb begin
    kind = REQ_NONE;
    if (is_std_dev) begin
      case (setup_i.b_request)
        8'h06: begin
          // GET_DESCRIPTOR, type in the high byte of wValue
          if (dir_in) begin
            case (setup_i.w_value[15:8])
              8'h01: kind = REQ_GET_DEVICE_DESC;
              8'h02: kind = REQ_GET_CONFIG_DESC;
              8'h03: kind = REQ_GET_STRING_DESC;
              default: kind = REQ_NONE;
            endcase
          end
        end
        8'h05: begin
          if (!dir_in) begin
            kind = REQ_SET_ADDRESS;
          end
        end
        8'h09: begin
          if (!dir_in) begin
            kind = REQ_SET_CONFIG;
          end
        end
        default: kind = REQ_NONE;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      request_valid_o <= 1'b0;
    end else begin
      request_valid_o <= setup_valid_i;
    end
  end

  always_ff @(posedge clock) begin
    if (setup_valid_i) begin
      request_o.kind       <= kind;
      request_o.desc_index <= setup_i.w_value[7:0];
      request_o.value      <= setup_i.w_value;
      request_o.length     <= setup_i.w_length;
    end
  end

endmodule

// File: source/setup_packet_parser.sv
module setup_packet_parser
  import usb_ctl_pkg::*;
(
  input  logic          clock,
  input  logic          reset,
  input  logic          setup_valid_i,
  input  logic [7:0]    setup_data_i,
  output setup_packet_t setup_o,
  output logic          setup_valid_o
);

  logic [2:0]    count_q;
  setup_packet_t pkt_q;
  setup_packet_t pkt_next;

  // Place the incoming byte by its position on the wire
  always_comb begin
    pkt_next = pkt_q;
    case (count_q)
      3'd0: pkt_next.bm_request_type = setup_data_i;
      3'd1: pkt_next.b_request = setup_data_i;
      3'd2: pkt_next.w_value[7:0] = setup_data_i;
      3'd3: pkt_next.w_value[15:8] = setup_data_i;
      3'd4: pkt_next.w_index[7:0] = setup_data_i;
      3'd5: pkt_next.w_index[15:8] = setup_data_i;
      3'd6: pkt_next.w_length[7:0] = setup_data_i;
      default: pkt_next.w_length[15:8] = setup_data_i;
    endcase
  end

  // Counter wraps after the eighth byte so the next packet starts at once
  always_ff @(posedge clock) begin
    if (reset) begin
      count_q       <= 3'd0;
      setup_valid_o <= 1'b0;
    end else begin
      setup_valid_o <= 1'b0;
      if (setup_valid_i) begin
        count_q <= count_q + 3'd1;
        if (count_q == 3'd7) begin
          setup_valid_o <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (setup_valid_i) begin
      pkt_q <= pkt_next;
      if (count_q == 3'd7) begin
        setup_o <= pkt_next;
      end
    end
  end

endmodule

// File: source/usb_ctl_pkg.sv
package usb_ctl_pkg;

  // SETUP packet in field order, multi-byte fields already little-endian combined
  typedef struct packed {
    logic [7:0]  bm_request_type;
    logic [7:0]  b_request;
    logic [15:0] w_value;
    logic [15:0] w_index;
    logic [15:0] w_length;
  } setup_packet_t;

  typedef enum logic [2:0] {
    REQ_NONE            = 3'd0,
    REQ_GET_DEVICE_DESC = 3'd1,
    REQ_GET_CONFIG_DESC = 3'd2,
    REQ_GET_STRING_DESC = 3'd3,
    REQ_SET_ADDRESS     = 3'd4,
    REQ_SET_CONFIG      = 3'd5
  } std_request_e;

  typedef struct packed {
    std_request_e kind;
    logic [7:0]   desc_index;
    logic [15:0]  value;
    logic [15:0]  length;
  } ctl_request_t;

  typedef enum logic [2:0] {
    CTL_IDLE             = 3'd0,
    CTL_STREAM           = 3'd1,
    CTL_WAIT_STATUS_ADDR = 3'd2,
    CTL_WAIT_STATUS_CONF = 3'd3,
    CTL_WAIT_STATUS      = 3'd4
  } ctl_state_e;

  localparam logic [15:0] VENDOR_ID  = 16'hface;
  localparam logic [15:0] PRODUCT_ID = 16'h0bde;

  localparam int DEVICE_DESC_LEN = 18;
  localparam int CONFIG_DESC_LEN = 18;
  localparam int LANG_DESC_LEN   = 4;
  // Product string is "Pipe0" in UTF-16LE
  localparam int PRODUCT_CHARS   = 5;
  localparam int PRODUCT_STR_LEN = 2 + 2 * PRODUCT_CHARS;

  localparam int CONFIG_START  = DEVICE_DESC_LEN;
  localparam int LANG_START    = CONFIG_START + CONFIG_DESC_LEN;
  localparam int PRODUCT_START = LANG_START + LANG_DESC_LEN;
  localparam int DESC_SIZE     = PRODUCT_START + PRODUCT_STR_LEN;
  localparam int DESC_ADDR_W   = $clog2(DESC_SIZE);
  localparam int NUM_STRINGS   = 2;

  localparam logic [7:0] DESC_ROM [DESC_SIZE] = '{
    // Device descriptor, USB 2.0, 64 byte EP0, one configuration
    8'h12, 8'h01, 8'h00, 8'h02, 8'hff, 8'h00, 8'h00, 8'h40,
    VENDOR_ID[7:0], VENDOR_ID[15:8], PRODUCT_ID[7:0], PRODUCT_ID[15:8],
    8'h00, 8'h01, 8'h00, 8'h01, 8'h00, 8'h01,
    // Configuration descriptor, self-powered, 100 mA
    8'h09, 8'h02, 8'(CONFIG_DESC_LEN), 8'h00, 8'h01, 8'h01, 8'h00, 8'hc0, 8'h32,
    // Interface descriptor with no endpoints
    8'h09, 8'h04, 8'h00, 8'h00, 8'h00, 8'hff, 8'h00, 8'h00, 8'h00,
    // String 0 lists US English only
    8'h04, 8'h03, 8'h09, 8'h04,
    // String 1 is the product name
    8'(PRODUCT_STR_LEN), 8'h03,
    8'h50, 8'h00, 8'h69, 8'h00, 8'h70, 8'h00, 8'h65, 8'h00, 8'h30, 8'h00
  };

endpackage
